// ==== Bender.yml ====
package:
  name: axi_mux

sources:
  - rtl/axi_mux_pkg.sv
  - rtl/stream_arbiter.sv
  - rtl/stream_fifo.sv
  - rtl/w_route_fsm.sv
  - rtl/resp_router.sv
  - rtl/axi_mux.sv

  - target: test
    files:
      - dv/axi_mux_asserts.sv
      - dv/tb_axi_mux.sv

// ==== dv/axi_mux_asserts.sv ====
`timescale 1ns/1ps

module axi_mux_asserts #(
    parameter int INPUT_NUM = 3
) (
    input logic                 ACLK,
    input logic                 ARESETn,
    input axi_mux_pkg::ax_req_t m_aw_o,
    input logic                 m_awvalid_o,
    input logic                 m_awready_i,
    input axi_mux_pkg::w_beat_t m_w_o,
    input logic                 m_wvalid_o,
    input logic                 m_wready_i,
    input axi_mux_pkg::ax_req_t m_ar_o,
    input logic                 m_arvalid_o,
    input logic                 m_arready_i,
    input logic [INPUT_NUM-1:0] s_bvalid_o,
    input logic [INPUT_NUM-1:0] s_rvalid_o
);

    int fail_cnt = 0;

    // Stalled payloads hold until the transfer
    aw_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_aw_o))
    else begin
        fail_cnt++;
        $error("m_aw dropped or changed while stalled");
    end

    w_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        m_wvalid_o && !m_wready_i |=> m_wvalid_o && $stable(m_w_o))
    else begin
        fail_cnt++;
        $error("m_w dropped or changed while stalled");
    end

    ar_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_ar_o))
    else begin
        fail_cnt++;
        $error("m_ar dropped or changed while stalled");
    end

    reset_quiet: assert property (@(posedge ACLK) !ARESETn |-> !m_awvalid_o && !m_wvalid_o)
    else begin
        fail_cnt++;
        $error("write valid high during reset");
    end

    // Payload is shared by all inputs, so two valids would share one ID
    resp_single: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $onehot0(s_bvalid_o) && $onehot0(s_rvalid_o))
    else begin
        fail_cnt++;
        $error("response valid on more than one input");
    end

endmodule

bind axi_mux axi_mux_asserts #(
    .INPUT_NUM (INPUT_NUM)
) i_asserts (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .m_aw_o      (m_aw_o),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready_i),
    .m_w_o       (m_w_o),
    .m_wvalid_o  (m_wvalid_o),
    .m_wready_i  (m_wready_i),
    .m_ar_o      (m_ar_o),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .s_bvalid_o  (s_bvalid_o),
    .s_rvalid_o  (s_rvalid_o)
);

// ==== dv/tb_axi_mux.sv ====
`timescale 1ns/1ps

module tb_axi_mux;

    import axi_mux_pkg::*;

    localparam int INPUT_NUM = 3;
    localparam int FIFO_LEN  = 4;
    localparam int NUM_ROWS  = 14;
    localparam int TIMEOUT   = 500;
    localparam int CH_AW     = 0;
    localparam int CH_W      = 1;
    localparam int CH_AR     = 2;

    // Phase, source, write flag, ID, address, length, data base
    typedef struct packed {
        logic [1:0]  phase;
        logic [1:0]  src;
        logic        wr;
        logic [3:0]  id;
        logic [15:0] addr;
        logic [7:0]  len;
        logic [31:0] base;
    } row_t;

    // Phase 0 round-robin reads, 1 mixed traffic, 2 AW back-pressure
    row_t stim [NUM_ROWS] = '{
        '{2'd0, 2'd0, 1'b0, 4'd1,  16'h0100, 8'd1, 32'h0},
        '{2'd0, 2'd1, 1'b0, 4'd5,  16'h0200, 8'd0, 32'h0},
        '{2'd0, 2'd2, 1'b0, 4'd9,  16'h0300, 8'd2, 32'h0},
        '{2'd1, 2'd0, 1'b1, 4'd2,  16'h1000, 8'd3, 32'h100},
        '{2'd1, 2'd1, 1'b1, 4'd6,  16'h2000, 8'd0, 32'h200},
        '{2'd1, 2'd2, 1'b1, 4'd12, 16'h3000, 8'd1, 32'h300},
        '{2'd1, 2'd0, 1'b0, 4'd3,  16'h0400, 8'd3, 32'h0},
        '{2'd1, 2'd2, 1'b0, 4'd15, 16'h0500, 8'd0, 32'h0},
        '{2'd2, 2'd0, 1'b1, 4'd0,  16'h4000, 8'd1, 32'h400},
        '{2'd2, 2'd1, 1'b1, 4'd4,  16'h5000, 8'd2, 32'h500},
        '{2'd2, 2'd2, 1'b1, 4'd8,  16'h6000, 8'd0, 32'h600},
        '{2'd2, 2'd0, 1'b1, 4'd1,  16'h4100, 8'd0, 32'h410},
        '{2'd2, 2'd1, 1'b1, 4'd7,  16'h5100, 8'd1, 32'h510},
        '{2'd2, 2'd2, 1'b1, 4'd10, 16'h6100, 8'd2, 32'h610}
    };

    logic                 ACLK = 1'b0;
    logic                 ARESETn;
    ax_req_t              s_aw_i [INPUT_NUM];
    logic [INPUT_NUM-1:0] s_awvalid_i;
    logic [INPUT_NUM-1:0] s_awready_o;
    w_beat_t              s_w_i [INPUT_NUM];
    logic [INPUT_NUM-1:0] s_wvalid_i;
    logic [INPUT_NUM-1:0] s_wready_o;
    b_resp_t              s_b_o [INPUT_NUM];
    logic [INPUT_NUM-1:0] s_bvalid_o;
    logic [INPUT_NUM-1:0] s_bready_i;
    ax_req_t              s_ar_i [INPUT_NUM];
    logic [INPUT_NUM-1:0] s_arvalid_i;
    logic [INPUT_NUM-1:0] s_arready_o;
    r_beat_t              s_r_o [INPUT_NUM];
    logic [INPUT_NUM-1:0] s_rvalid_o;
    logic [INPUT_NUM-1:0] s_rready_i;
    ax_req_t              m_aw_o;
    logic                 m_awvalid_o;
    logic                 m_awready_i;
    w_beat_t              m_w_o;
    logic                 m_wvalid_o;
    logic                 m_wready_i;
    b_resp_t              m_b_i;
    logic                 m_bvalid_i;
    logic                 m_bready_o;
    ax_req_t              m_ar_o;
    logic                 m_arvalid_o;
    logic                 m_arready_i;
    r_beat_t              m_r_i;
    logic                 m_rvalid_i;
    logic                 m_rready_o;

    integer     seed = 95579;
    int         mismatches = 0;
    int         timeouts = 0;
    bit         hold_aw = 1'b0;
    ax_req_t    down_aw_q [$];
    w_beat_t    down_w_q [$];
    logic [3:0] down_ar_ids [$];
    logic [3:0] up_aw_ids [$];
    ax_req_t    ar_pend_q [$];
    int         r_beat = 0;
    int         b_issued = 0;
    int         wlast_cnt = 0;
    int         b_seen [16] = '{default: 0};
    int         r_seen [16] = '{default: 0};

    axi_mux i_dut (.*);

    always #4 ACLK = ~ACLK;

    // ID ranges 0-3, 4-7, rest
    function automatic int owner_of(input logic [3:0] id);
        if (id <= 4'd3) begin
            return 0;
        end else if (id <= 4'd7) begin
            return 1;
        end
        return 2;
    endfunction

    function automatic logic [31:0] read_data(input logic [15:0] addr, input int k);
        return {~addr, addr + 16'(4 * k)};
    endfunction

    function automatic int find_row(input logic wr, input logic [3:0] id);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (stim[i].wr == wr && stim[i].id == id) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic ready_of(input int ch, input int src);
        case (ch)
            CH_AW:   return s_awready_o[src];
            CH_W:    return s_wready_o[src];
            default: return s_arready_o[src];
        endcase
    endfunction

    function automatic bit phase_done(input int phase);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (stim[i].phase == phase) begin
                if (stim[i].wr && b_seen[stim[i].id] == 0) begin
                    return 1'b0;
                end
                if (!stim[i].wr && r_seen[stim[i].id] <= int'(stim[i].len)) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("MISMATCH @%0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = i_dut.i_asserts.fail_cnt;
        $display("Error counts: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, assert_fails);
        if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("TIMEOUT @%0t: gave up waiting for %s", $time, what);
        finish_run();
    endtask

    // Hold valid until ready is seen, then step to 1 ns after the transfer edge
    task automatic wait_ready(input int ch, input int src);
        int n;
        n = 0;
        @(negedge ACLK);
        while (!ready_of(ch, src)) begin
            n++;
            if (n > TIMEOUT) begin
                report_timeout($sformatf("ready on channel %0d of source %0d", ch, src));
            end
            @(negedge ACLK);
        end
        @(posedge ACLK);
        #1;
    endtask

    task automatic send_aw(input int src, input row_t r);
        s_aw_i[src] = '{id: r.id, addr: r.addr, len: r.len, size: 3'd2, burst: 2'b01};
        s_awvalid_i[src] = 1'b1;
        wait_ready(CH_AW, src);
        s_awvalid_i[src] = 1'b0;
        up_aw_ids.push_back(r.id);
    endtask

    task automatic send_w(input int src, input row_t r);
        for (int k = 0; k <= int'(r.len); k++) begin
            s_w_i[src].data = r.base + 32'(k);
            s_w_i[src].strb = 4'hf;
            s_w_i[src].last = (k == int'(r.len));
            s_wvalid_i[src] = 1'b1;
            wait_ready(CH_W, src);
        end
        s_wvalid_i[src] = 1'b0;
    endtask

    task automatic send_ar(input int src, input row_t r);
        s_ar_i[src] = '{id: r.id, addr: r.addr, len: r.len, size: 3'd2, burst: 2'b01};
        s_arvalid_i[src] = 1'b1;
        wait_ready(CH_AR, src);
        s_arvalid_i[src] = 1'b0;
    endtask

    // AW, W and AR of one source run side by side
    task automatic run_source(input int phase, input int src);
        fork
            for (int i = 0; i < NUM_ROWS; i++) begin
                if (stim[i].phase == phase && stim[i].src == src && stim[i].wr) begin
                    send_aw(src, stim[i]);
                end
            end
            for (int i = 0; i < NUM_ROWS; i++) begin
                if (stim[i].phase == phase && stim[i].src == src && stim[i].wr) begin
                    send_w(src, stim[i]);
                end
            end
            for (int i = 0; i < NUM_ROWS; i++) begin
                if (stim[i].phase == phase && stim[i].src == src && !stim[i].wr) begin
                    send_ar(src, stim[i]);
                end
            end
        join
    endtask

    task automatic run_phase(input int phase);
        fork
            run_source(phase, 0);
            run_source(phase, 1);
            run_source(phase, 2);
        join
    endtask

    task automatic wait_responses(input int phase);
        int n;
        n = 0;
        while (!phase_done(phase)) begin
            n++;
            if (n > TIMEOUT) begin
                report_timeout($sformatf("B and R responses of phase %0d", phase));
            end
            @(negedge ACLK);
        end
        @(posedge ACLK);
        #1;
    endtask

    task automatic check_backpressure(input int aw_base);
        int n;
        n = 0;
        @(negedge ACLK);
        while (s_awready_o != '0) begin
            n++;
            if (n > TIMEOUT) begin
                report_timeout("the AW queue to fill");
            end
            @(negedge ACLK);
        end
        // A few more cycles in which no further AW may slip in
        repeat (8) @(negedge ACLK);
        assert (up_aw_ids.size() - aw_base == FIFO_LEN && s_awready_o == '0)
        else report_mismatch($sformatf("%0d AW transfers under back-pressure, expected %0d",
                                       up_aw_ids.size() - aw_base, FIFO_LEN));
        hold_aw = 1'b0;
    endtask

    // Downstream AW order and the beats behind each AW
    task automatic check_writes();
        int row;
        int beat;
        int writes;
        ax_req_t aw;
        w_beat_t w;
        beat = 0;
        writes = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            writes += int'(stim[i].wr);
        end
        assert (down_aw_q.size() == writes && up_aw_ids.size() == writes)
        else report_mismatch($sformatf("%0d AWs downstream, %0d upstream, expected %0d",
                                       down_aw_q.size(), up_aw_ids.size(), writes));
        for (int i = 0; i < down_aw_q.size(); i++) begin
            aw = down_aw_q[i];
            row = find_row(1'b1, aw.id);
            assert (i < up_aw_ids.size() && aw.id == up_aw_ids[i])
            else report_mismatch($sformatf("AW %0d with ID %0d out of order", i, aw.id));
            assert (row >= 0 && aw.addr == stim[row].addr && aw.len == stim[row].len)
            else report_mismatch($sformatf("AW ID %0d addr %h len %0d", aw.id, aw.addr, aw.len));
            if (row >= 0) begin
                for (int k = 0; k <= int'(aw.len); k++) begin
                    if (beat < down_w_q.size()) begin
                        w = down_w_q[beat];
                        assert (w.data == stim[row].base + 32'(k) && w.strb == 4'hf
                                && w.last == (k == int'(aw.len)))
                        else report_mismatch($sformatf("W beat %0d of ID %0d: data %h last %b",
                                                       k, aw.id, w.data, w.last));
                    end
                    beat++;
                end
            end
        end
        assert (beat == down_w_q.size())
        else report_mismatch($sformatf("%0d W beats, expected %0d", down_w_q.size(), beat));
    endtask

    // Subordinate model
    always begin
        bit b_fire;
        bit r_fire;
        @(negedge ACLK);
        b_fire = m_bvalid_i && m_bready_o;
        r_fire = m_rvalid_i && m_rready_o;
        if (m_awvalid_o && m_awready_i) begin
            down_aw_q.push_back(m_aw_o);
        end
        if (m_wvalid_o && m_wready_i) begin
            down_w_q.push_back(m_w_o);
            wlast_cnt += int'(m_w_o.last);
        end
        if (m_arvalid_o && m_arready_i) begin
            ar_pend_q.push_back(m_ar_o);
            down_ar_ids.push_back(m_ar_o.id);
        end
        @(posedge ACLK);
        #1;
        m_awready_i = hold_aw ? 1'b0 : (($random(seed) & 3) != 0);
        m_wready_i  = ($random(seed) & 3) != 0;
        m_arready_i = ($random(seed) & 3) != 0;
        // Managers stall responses now and then
        s_rready_i  = 3'($random(seed)) | 3'($random(seed));
        s_bready_i  = 3'($random(seed)) | 3'($random(seed));
        if (b_fire) begin
            m_bvalid_i = 1'b0;
        end
        // B once both the AW and its last beat are in
        if (!m_bvalid_i && b_issued < down_aw_q.size() && b_issued < wlast_cnt) begin
            m_b_i.id   = down_aw_q[b_issued].id;
            m_bvalid_i = 1'b1;
            b_issued++;
        end
        if (r_fire) begin
            if (r_beat == int'(ar_pend_q[0].len)) begin
                void'(ar_pend_q.pop_front());
                r_beat = 0;
            end else begin
                r_beat++;
            end
        end
        m_rvalid_i = 1'b0;
        if (ar_pend_q.size() > 0) begin
            m_r_i.id   = ar_pend_q[0].id;
            m_r_i.data = read_data(ar_pend_q[0].addr, r_beat);
            m_r_i.last = (r_beat == int'(ar_pend_q[0].len));
            m_rvalid_i = 1'b1;
        end
    end

    // Upstream response checks
    always @(negedge ACLK) begin
        int row;
        logic [3:0] id;
        if (ARESETn) begin
            for (int s = 0; s < INPUT_NUM; s++) begin
                if (s_bvalid_o[s]) begin
                    id = s_b_o[s].id;
                    assert (owner_of(id) == s && find_row(1'b1, id) >= 0)
                    else report_mismatch($sformatf("B ID %0d seen on source %0d", id, s));
                    if (s_bready_i[s]) begin
                        assert (b_seen[id] == 0)
                        else report_mismatch($sformatf("B ID %0d returned twice", id));
                        b_seen[id]++;
                    end
                end
                if (s_rvalid_o[s]) begin
                    id = s_r_o[s].id;
                    row = find_row(1'b0, id);
                    assert (owner_of(id) == s && row >= 0)
                    else report_mismatch($sformatf("R ID %0d seen on source %0d", id, s));
                    if (s_rready_i[s] && row >= 0) begin
                        assert (s_r_o[s].data == read_data(stim[row].addr, r_seen[id])
                                && s_r_o[s].last == (r_seen[id] == int'(stim[row].len)))
                        else report_mismatch($sformatf("R beat %0d of ID %0d: data %h last %b",
                                                       r_seen[id], id, s_r_o[s].data,
                                                       s_r_o[s].last));
                        r_seen[id]++;
                    end
                end
            end
        end
    end

    initial begin
        int aw_base;
        for (int i = 0; i < INPUT_NUM; i++) begin
            s_aw_i[i] = '0;
            s_w_i[i]  = '0;
            s_ar_i[i] = '0;
        end
        s_awvalid_i = '0;
        s_wvalid_i  = '0;
        s_arvalid_i = '0;
        s_bready_i  = '1;
        s_rready_i  = '1;
        m_awready_i = 1'b0;
        m_wready_i  = 1'b0;
        m_arready_i = 1'b0;
        m_b_i       = '0;
        m_bvalid_i  = 1'b0;
        m_r_i       = '0;
        m_rvalid_i  = 1'b0;
        ARESETn     = 1'b0;
        repeat (3) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;
        @(negedge ACLK);
        assert (!m_awvalid_o && !m_wvalid_o && !m_arvalid_o)
        else report_mismatch("downstream valid high right after reset");
        @(posedge ACLK);
        #1;

        run_phase(0);
        wait_responses(0);
        assert (down_ar_ids.size() == 3 && down_ar_ids[0] == 4'd1
                && down_ar_ids[1] == 4'd5 && down_ar_ids[2] == 4'd9)
        else report_mismatch("AR grants after reset not in order 0, 1, 2");

        run_phase(1);
        wait_responses(1);

        @(negedge ACLK);
        hold_aw = 1'b1;
        @(posedge ACLK);
        #1;
        aw_base = up_aw_ids.size();
        fork
            run_phase(2);
            check_backpressure(aw_base);
        join
        wait_responses(2);

        check_writes();
        finish_run();
    end

endmodule

// ==== rtl/axi_mux.sv ====
`timescale 1ns/1ps

module axi_mux #(
    parameter int INPUT_NUM = 3,
    parameter int FIFO_LEN  = 4,
    parameter int ID_ROUTING [2*(INPUT_NUM-1)] = '{0, 3, 4, 7}
) (
    input  logic                 ACLK,
    input  logic                 ARESETn,

    // Upstream managers
    input  axi_mux_pkg::ax_req_t s_aw_i [INPUT_NUM],
    input  logic [INPUT_NUM-1:0] s_awvalid_i,
    output logic [INPUT_NUM-1:0] s_awready_o,

    input  axi_mux_pkg::w_beat_t s_w_i [INPUT_NUM],
    input  logic [INPUT_NUM-1:0] s_wvalid_i,
    output logic [INPUT_NUM-1:0] s_wready_o,

    output axi_mux_pkg::b_resp_t s_b_o [INPUT_NUM],
    output logic [INPUT_NUM-1:0] s_bvalid_o,
    input  logic [INPUT_NUM-1:0] s_bready_i,

    input  axi_mux_pkg::ax_req_t s_ar_i [INPUT_NUM],
    input  logic [INPUT_NUM-1:0] s_arvalid_i,
    output logic [INPUT_NUM-1:0] s_arready_o,

    output axi_mux_pkg::r_beat_t s_r_o [INPUT_NUM],
    output logic [INPUT_NUM-1:0] s_rvalid_o,
    input  logic [INPUT_NUM-1:0] s_rready_i,

    // Downstream subordinate
    output axi_mux_pkg::ax_req_t m_aw_o,
    output logic                 m_awvalid_o,
    input  logic                 m_awready_i,

    output axi_mux_pkg::w_beat_t m_w_o,
    output logic                 m_wvalid_o,
    input  logic                 m_wready_i,

    input  axi_mux_pkg::b_resp_t m_b_i,
    input  logic                 m_bvalid_i,
    output logic                 m_bready_o,

    output axi_mux_pkg::ax_req_t m_ar_o,
    output logic                 m_arvalid_o,
    input  logic                 m_arready_i,

    input  axi_mux_pkg::r_beat_t m_r_i,
    input  logic                 m_rvalid_i,
    output logic                 m_rready_o
);

    import axi_mux_pkg::*;

    // Arbiter to FIFO
    ax_req_t arb_aw;
    logic    arb_aw_valid;
    logic    arb_aw_ready;

    // FIFO head to write steering
    ax_req_t fifo_aw;
    logic    fifo_aw_valid;
    logic    fifo_aw_ready;

    stream_arbiter #(
        .INPUT_NUM (INPUT_NUM)
    ) i_aw_arb (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .valid_i (s_awvalid_i),
        .data_i  (s_aw_i),
        .ready_o (s_awready_o),
        .valid_o (arb_aw_valid),
        .data_o  (arb_aw),
        .ready_i (arb_aw_ready)
    );

    stream_fifo #(
        .FIFO_LEN (FIFO_LEN)
    ) i_aw_fifo (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .valid_i (arb_aw_valid),
        .data_i  (arb_aw),
        .ready_o (arb_aw_ready),
        .valid_o (fifo_aw_valid),
        .data_o  (fifo_aw),
        .ready_i (fifo_aw_ready)
    );

    w_route_fsm #(
        .INPUT_NUM  (INPUT_NUM),
        .ID_ROUTING (ID_ROUTING)
    ) i_w_route (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .aw_valid_i  (fifo_aw_valid),
        .aw_i        (fifo_aw),
        .aw_ready_o  (fifo_aw_ready),
        .m_awvalid_o (m_awvalid_o),
        .m_aw_o      (m_aw_o),
        .m_awready_i (m_awready_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_w_i       (s_w_i),
        .s_wready_o  (s_wready_o),
        .m_wvalid_o  (m_wvalid_o),
        .m_w_o       (m_w_o),
        .m_wready_i  (m_wready_i)
    );

    // Reads go straight out, no queue
    stream_arbiter #(
        .INPUT_NUM (INPUT_NUM)
    ) i_ar_arb (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .valid_i (s_arvalid_i),
        .data_i  (s_ar_i),
        .ready_o (s_arready_o),
        .valid_o (m_arvalid_o),
        .data_o  (m_ar_o),
        .ready_i (m_arready_i)
    );

    resp_router #(
        .INPUT_NUM  (INPUT_NUM),
        .ID_ROUTING (ID_ROUTING)
    ) i_resp_route (
        .m_b_i      (m_b_i),
        .m_bvalid_i (m_bvalid_i),
        .m_bready_o (m_bready_o),
        .s_b_o      (s_b_o),
        .s_bvalid_o (s_bvalid_o),
        .s_bready_i (s_bready_i),
        .m_r_i      (m_r_i),
        .m_rvalid_i (m_rvalid_i),
        .m_rready_o (m_rready_o),
        .s_r_o      (s_r_o),
        .s_rvalid_o (s_rvalid_o),
        .s_rready_i (s_rready_i)
    );

endmodule

// ==== rtl/axi_mux_pkg.sv ====
package axi_mux_pkg;

    // AXI field widths shared by every channel
    localparam int ID_WIDTH   = 4;
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Burst fields
    localparam int LEN_WIDTH   = 8;
    localparam int SIZE_WIDTH  = 3;
    localparam int BURST_WIDTH = 2;

    // One AW or AR request, 33 bits
    typedef struct packed {
        logic [ID_WIDTH-1:0]    id;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [LEN_WIDTH-1:0]   len;
        logic [SIZE_WIDTH-1:0]  size;
        logic [BURST_WIDTH-1:0] burst;
    } ax_req_t;

    // One write data beat
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } w_beat_t;

    // Write response, ID only since resp is not carried
    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
    } b_resp_t;

    // One read data beat
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
    } r_beat_t;

    // Write data steering states
    //   W_IDLE  next AW not yet accepted downstream
    //   W_BURST data of the accepted AW is flowing
    typedef enum logic {
        W_IDLE,
        W_BURST
    } w_state_e;

endpackage

// ==== rtl/resp_router.sv ====
`timescale 1ns/1ps

module resp_router #(
    parameter int INPUT_NUM = 3,
    parameter int ID_ROUTING [2*(INPUT_NUM-1)] = '{0, 3, 4, 7}
) (
    input  axi_mux_pkg::b_resp_t m_b_i,
    input  logic                 m_bvalid_i,
    output logic                 m_bready_o,

    output axi_mux_pkg::b_resp_t s_b_o [INPUT_NUM],
    output logic [INPUT_NUM-1:0] s_bvalid_o,
    input  logic [INPUT_NUM-1:0] s_bready_i,

    input  axi_mux_pkg::r_beat_t m_r_i,
    input  logic                 m_rvalid_i,
    output logic                 m_rready_o,

    output axi_mux_pkg::r_beat_t s_r_o [INPUT_NUM],
    output logic [INPUT_NUM-1:0] s_rvalid_o,
    input  logic [INPUT_NUM-1:0] s_rready_i
);

    import axi_mux_pkg::*;

    localparam int IDX_W = (INPUT_NUM > 1) ? $clog2(INPUT_NUM) : 1;

    logic [IDX_W-1:0] b_owner;
    logic [IDX_W-1:0] r_owner;

    function automatic logic [IDX_W-1:0] id_owner(input logic [ID_WIDTH-1:0] id);
        logic [IDX_W-1:0] owner;
        owner = IDX_W'(INPUT_NUM - 1);
        for (int j = 0; j < INPUT_NUM - 1; j++) begin
            if (id >= ID_ROUTING[2*j] && id <= ID_ROUTING[2*j+1]) begin
                owner = IDX_W'(j);
            end
        end
        return owner;
    endfunction

    assign b_owner = id_owner(m_b_i.id);
    assign r_owner = id_owner(m_r_i.id);

    // Payload is broadcast, only the owner sees valid
    always_comb begin
        s_bvalid_o          = '0;
        s_bvalid_o[b_owner] = m_bvalid_i;
        m_bready_o          = s_bready_i[b_owner];
        for (int i = 0; i < INPUT_NUM; i++) begin
            s_b_o[i] = m_b_i;
        end
    end

    always_comb begin
        s_rvalid_o          = '0;
        s_rvalid_o[r_owner] = m_rvalid_i;
        m_rready_o          = s_rready_i[r_owner];
        for (int i = 0; i < INPUT_NUM; i++) begin
            s_r_o[i] = m_r_i;
        end
    end

endmodule

// ==== rtl/stream_arbiter.sv ====
`timescale 1ns/1ps

module stream_arbiter #(
    parameter int INPUT_NUM = 3
) (
    input  logic                 ACLK,
    input  logic                 ARESETn,

    input  logic [INPUT_NUM-1:0] valid_i,
    input  axi_mux_pkg::ax_req_t data_i [INPUT_NUM],
    output logic [INPUT_NUM-1:0] ready_o,

    output logic                 valid_o,
    output axi_mux_pkg::ax_req_t data_o,
    input  logic                 ready_i
);

    localparam int IDX_W = (INPUT_NUM > 1) ? $clog2(INPUT_NUM) : 1;

    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] lock_idx_q;
    logic             lock_q;
    logic [IDX_W-1:0] search_idx;
    logic [IDX_W-1:0] grant_idx;

    // Round-robin search starting at the pointer
    always_comb begin
        int cand;
        search_idx = ptr_q;
        // Walk backwards so the closest requester to the pointer wins
        for (int k = INPUT_NUM - 1; k >= 0; k--) begin
            cand = int'(ptr_q) + k;
            if (cand >= INPUT_NUM) begin
                cand = cand - INPUT_NUM;
            end
            if (valid_i[cand]) begin
                search_idx = IDX_W'(cand);
            end
        end
    end

    // Held grant keeps the payload stable while stalled
    assign grant_idx = lock_q ? lock_idx_q : search_idx;

    assign valid_o = valid_i[grant_idx];
    assign data_o  = data_i[grant_idx];

    always_comb begin
        ready_o            = '0;
        ready_o[grant_idx] = ready_i;
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            ptr_q      <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            if (valid_o && ready_i) begin
                lock_q <= 1'b0;
                // Next search starts after the winner
                if (grant_idx == IDX_W'(INPUT_NUM - 1)) begin
                    ptr_q <= '0;
                end else begin
                    ptr_q <= grant_idx + 1'b1;
                end
            end else if (valid_o) begin
                lock_q     <= 1'b1;
                lock_idx_q <= grant_idx;
            end
        end
    end

endmodule

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
    parameter int FIFO_LEN = 4
) (
    input  logic                 ACLK,
    input  logic                 ARESETn,

    input  logic                 valid_i,
    input  axi_mux_pkg::ax_req_t data_i,
    output logic                 ready_o,

    output logic                 valid_o,
    output axi_mux_pkg::ax_req_t data_o,
    input  logic                 ready_i
);

    import axi_mux_pkg::*;

    localparam int PTR_W = (FIFO_LEN > 1) ? $clog2(FIFO_LEN) : 1;
    localparam int CNT_W = $clog2(FIFO_LEN + 1);

    ax_req_t          mem_q [FIFO_LEN];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             push;
    logic             pop;

    assign full    = (count_q == CNT_W'(FIFO_LEN));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    assign pop     = valid_o && ready_i;
    // A read frees the slot in the same cycle
    assign ready_o = !full || pop;
    assign push    = valid_i && ready_o;

    always_ff @(posedge ACLK) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_LEN - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_LEN - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== rtl/w_route_fsm.sv ====
`timescale 1ns/1ps

module w_route_fsm #(
    parameter int INPUT_NUM = 3,
    parameter int ID_ROUTING [2*(INPUT_NUM-1)] = '{0, 3, 4, 7}
) (
    input  logic                 ACLK,
    input  logic                 ARESETn,

    input  logic                 aw_valid_i,
    input  axi_mux_pkg::ax_req_t aw_i,
    output logic                 aw_ready_o,

    output logic                 m_awvalid_o,
    output axi_mux_pkg::ax_req_t m_aw_o,
    input  logic                 m_awready_i,

    input  logic [INPUT_NUM-1:0] s_wvalid_i,
    input  axi_mux_pkg::w_beat_t s_w_i [INPUT_NUM],
    output logic [INPUT_NUM-1:0] s_wready_o,

    output logic                 m_wvalid_o,
    output axi_mux_pkg::w_beat_t m_w_o,
    input  logic                 m_wready_i
);

    import axi_mux_pkg::*;

    localparam int IDX_W = (INPUT_NUM > 1) ? $clog2(INPUT_NUM) : 1;

    w_state_e         state_q;
    w_state_e         state_d;
    logic [IDX_W-1:0] owner_q;
    logic [IDX_W-1:0] head_owner;
    logic [IDX_W-1:0] sel;
    logic             w_en;
    logic             aw_fire;
    logic             w_last_fire;
    logic             wlast_seen_q;
    logic             wlast_seen_d;

    // Last input takes every ID outside the listed ranges
    function automatic logic [IDX_W-1:0] id_owner(input logic [ID_WIDTH-1:0] id);
        logic [IDX_W-1:0] owner;
        owner = IDX_W'(INPUT_NUM - 1);
        for (int j = 0; j < INPUT_NUM - 1; j++) begin
            if (id >= ID_ROUTING[2*j] && id <= ID_ROUTING[2*j+1]) begin
                owner = IDX_W'(j);
            end
        end
        return owner;
    endfunction

    assign head_owner = id_owner(aw_i.id);

    // AW goes out only between bursts
    assign m_aw_o      = aw_i;
    assign m_awvalid_o = (state_q == W_IDLE) && aw_valid_i;
    assign aw_ready_o  = (state_q == W_IDLE) && m_awready_i;
    assign aw_fire     = m_awvalid_o && m_awready_i;

    // Early data of the head burst may pass before its AW is taken
    assign sel  = (state_q == W_IDLE) ? head_owner : owner_q;
    assign w_en = (state_q == W_BURST) || (aw_valid_i && !wlast_seen_q);

    assign m_w_o       = s_w_i[sel];
    assign m_wvalid_o  = w_en && s_wvalid_i[sel];
    assign w_last_fire = m_wvalid_o && m_wready_i && m_w_o.last;

    always_comb begin
        s_wready_o      = '0;
        s_wready_o[sel] = w_en && m_wready_i;
    end

    always_comb begin
        state_d      = state_q;
        wlast_seen_d = wlast_seen_q;
        case (state_q)
            W_IDLE: begin
                if (aw_fire) begin
                    wlast_seen_d = 1'b0;
                    // Whole burst already sent, nothing left to steer
                    if (!(w_last_fire || wlast_seen_q)) begin
                        state_d = W_BURST;
                    end
                end else if (w_last_fire) begin
                    wlast_seen_d = 1'b1;
                end
            end
            W_BURST: begin
                if (w_last_fire) begin
                    state_d = W_IDLE;
                end
            end
            default: state_d = W_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q      <= W_IDLE;
            owner_q      <= '0;
            wlast_seen_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            wlast_seen_q <= wlast_seen_d;
            if (aw_fire) begin
                owner_q <= head_owner;
            end
        end
    end

endmodule

// ==== tb.f ====
rtl/axi_mux_pkg.sv
rtl/stream_arbiter.sv
rtl/stream_fifo.sv
rtl/w_route_fsm.sv
rtl/resp_router.sv
rtl/axi_mux.sv
dv/axi_mux_asserts.sv
dv/tb_axi_mux.sv
